// File: core.f
isa_pkg.sv
pipe_pkg.sv
fetch_unit.sv
inst_decode.sv
pipeline_control.sv
reg_file.sv
execute_unit.sv
core.sv
tb_core.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f core.f --top-module tb_core -o tb_core &&
./obj_dir/tb_core | tee /dev/stderr | grep -q "Done: no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tb_core.sv
// Testbench for the in-order core. Runs a random RV32 program from a fixed
// seed through an icache model with random valid gaps, and checks every
// store and the fetch address against a sequential model of the program.
module tb_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          LINE_WORDS   = 4;
  localparam logic [31:0] RESET_PC     = 32'h0;
  localparam int          CLK_PERIOD   = 4;
  localparam int          RESET_CYCLES = 3;
  localparam int          PROG_WORDS   = 256;
  localparam int          DRAIN_CYCLES = 30;
  localparam int          TIMEOUT_NS   = PROG_WORDS * 15 * CLK_PERIOD;
  localparam logic [31:0] LINE_BYTES   = 32'(LINE_WORDS * 4);
  localparam logic [31:0] PROG_END     = RESET_PC + 32'(PROG_WORDS * 4);

  logic                     clock = 1'b0;
  logic                     reset;
  logic [31:0]              icache_addr;
  logic [LINE_WORDS*32-1:0] icache_data;
  logic                     icache_valid;
  pipe_pkg::store_req_t     dcache_store;

  logic [31:0]              prog [0:PROG_WORDS-1];
  logic [31:0]              model_regs [0:31];
  pipe_pkg::store_req_t     expected_stores [$];
  integer                   seed = 3;
  int                       errors = 0;
  int                       stores_seen = 0;
  int                       stores_expected = 0;
  logic [31:0]              last_addr = RESET_PC;
  logic                     line_offered = 1'b0;

  core #(
    .LINE_WORDS (LINE_WORDS),
    .RESET_PC   (RESET_PC)
  ) dut0 (
    .clock        (clock),
    .reset        (reset),
    .icache_addr  (icache_addr),
    .icache_data  (icache_data),
    .icache_valid (icache_valid),
    .dcache_store (dcache_store)
  );

  initial begin
    forever begin
      #(CLK_PERIOD / 2) clock = ~clock;
    end
  end

  function automatic logic [31:0] sign_ext12(input logic [11:0] value);
    return {{20{value[11]}}, value};
  endfunction

  function automatic logic [31:0] encode_r(input logic [6:0] funct7, input logic [2:0] funct3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] encode_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] encode_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  task automatic build_program;
    logic [31:0] rnd;
    logic [31:0] rnd_imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    // x0 write and x0 store followed by a dependent pair
    prog[0] = encode_addi(5'd0, 5'd0, 12'h7ff);
    prog[1] = encode_sw(5'd0, 5'd0, 12'h040);
    prog[2] = encode_addi(5'd1, 5'd0, 12'h005);
    prog[3] = encode_r(7'h00, 3'b000, 5'd2, 5'd1, 5'd1);
    prog[4] = encode_sw(5'd2, 5'd1, 12'h000);
    for (int i = 5; i < PROG_WORDS; i++) begin
      rnd     = $random(seed);
      rnd_imm = $random(seed);
      rd      = {2'b00, rnd[2:0]};
      rs1     = {2'b00, rnd[5:3]};
      rs2     = {2'b00, rnd[8:6]};
      if (rnd[12:9] < 4'd6) begin
        case (rnd[15:13])
          3'd1:    prog[i] = encode_r(7'h20, 3'b000, rd, rs1, rs2);
          3'd2:    prog[i] = encode_r(7'h00, 3'b100, rd, rs1, rs2);
          3'd3:    prog[i] = encode_r(7'h00, 3'b110, rd, rs1, rs2);
          3'd4:    prog[i] = encode_r(7'h00, 3'b111, rd, rs1, rs2);
          default: prog[i] = encode_r(7'h00, 3'b000, rd, rs1, rs2);
        endcase
      end else if (rnd[12:9] < 4'd10) begin
        prog[i] = encode_addi(rd, rs1, rnd_imm[11:0]);
      end else if (rnd[12:9] < 4'd14) begin
        prog[i] = encode_sw(rs2, rs1, rnd_imm[11:0]);
      end else begin
        // random word that is mostly an unsupported encoding
        prog[i] = rnd_imm;
      end
    end
  endtask

  // executes the program in order and queues the stores it makes
  task automatic run_model;
    logic [31:0]          word;
    logic [31:0]          src1;
    logic [31:0]          src2;
    logic [31:0]          result;
    logic                 writes;
    pipe_pkg::store_req_t req;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    for (int i = 0; i < PROG_WORDS; i++) begin
      word   = prog[i];
      src1   = model_regs[word[19:15]];
      src2   = model_regs[word[24:20]];
      writes = 1'b0;
      result = '0;
      case (word[6:0])
        7'b0110011: begin
          writes = 1'b1;
          case ({word[31:25], word[14:12]})
            {7'h00, 3'b000}: result = src1 + src2;
            {7'h20, 3'b000}: result = src1 - src2;
            {7'h00, 3'b100}: result = src1 ^ src2;
            {7'h00, 3'b110}: result = src1 | src2;
            {7'h00, 3'b111}: result = src1 & src2;
            default:         writes = 1'b0;
          endcase
        end
        7'b0010011: begin
          if (word[14:12] == 3'b000) begin
            writes = 1'b1;
            result = src1 + sign_ext12(word[31:20]);
          end
        end
        7'b0100011: begin
          if (word[14:12] == 3'b010) begin
            req.we   = 1'b1;
            req.addr = src1 + sign_ext12({word[31:25], word[11:7]});
            req.data = src2;
            expected_stores.push_back(req);
          end
        end
        default: ;
      endcase
      if (writes && word[11:7] != 5'd0) begin
        model_regs[word[11:7]] = result;
      end
    end
    stores_expected = expected_stores.size();
  endtask

  // words past the program read as zero
  function automatic logic [LINE_WORDS*32-1:0] line_at(input logic [31:0] addr);
    logic [LINE_WORDS*32-1:0] line;
    int                       idx;
    line = '0;
    for (int k = 0; k < LINE_WORDS; k++) begin
      idx = int'((addr - RESET_PC) >> 2) + k;
      if (idx >= 0 && idx < PROG_WORDS) begin
        line[k*32 +: 32] = prog[idx];
      end
    end
    return line;
  endfunction

  task automatic check_store(input pipe_pkg::store_req_t actual,
                             input pipe_pkg::store_req_t expected);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0t dcache_store got we=%b addr=%h data=%h expected we=%b addr=%h data=%h",
               $time, actual.we, actual.addr, actual.data,
               expected.we, expected.addr, expected.data);
    end
  endtask

  task automatic check_addr(input logic [31:0] actual, input logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0t icache_addr got %h expected %h", $time, actual, expected);
    end
  endtask

  task automatic check_fetch_advance;
    if (icache_addr !== last_addr) begin
      if (!line_offered) begin
        errors++;
        $display("icache_addr moved at %0t although no line was offered", $time);
      end
      check_addr(icache_addr, last_addr + LINE_BYTES);
      last_addr    = icache_addr;
      line_offered = 1'b0;
    end
  endtask

  task automatic check_store_output;
    if (dcache_store.we === 1'b1) begin
      stores_seen++;
      if (expected_stores.size() == 0) begin
        errors++;
        $display("store to %h at %0t when the model has no store left", dcache_store.addr, $time);
      end else begin
        check_store(dcache_store, expected_stores.pop_front());
      end
    end else if (dcache_store.we !== 1'b0) begin
      errors++;
      $display("FAIL %0t dcache_store.we got %b expected 0", $time, dcache_store.we);
    end
  endtask

  // reset, icache model and output monitors all run on the falling edge
  initial begin
    logic [31:0] rnd;
    int          cycle;
    reset        = 1'b1;
    icache_valid = 1'b0;
    icache_data  = '0;
    cycle        = 0;
    forever begin
      @(negedge clock);
      cycle++;
      if (reset) begin
        check_addr(icache_addr, RESET_PC);
        if (dcache_store.we !== 1'b0) begin
          errors++;
          $display("FAIL %0t dcache_store.we got %b expected 0", $time, dcache_store.we);
        end
      end else begin
        check_fetch_advance();
        check_store_output();
      end
      if (cycle == RESET_CYCLES) begin
        reset = 1'b0;
      end
      rnd          = $random(seed);
      icache_valid = rnd[0];
      icache_data  = line_at(icache_addr);
      if (icache_valid && !reset) begin
        line_offered = 1'b1;
      end
    end
  end

  initial begin
    build_program();
    run_model();
    wait (icache_addr >= PROG_END);
    repeat (DRAIN_CYCLES) @(posedge clock);
    if (stores_seen != stores_expected) begin
      errors++;
      $display("FAIL %0t store count got %0d expected %0d", $time, stores_seen, stores_expected);
    end
    $display("%0d stores checked, %0d errors", stores_seen, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog allows about 15 cycles per instruction
  initial begin
    #(TIMEOUT_NS);
    $display("timeout after %0d ns, the program did not drain", TIMEOUT_NS);
    $display("%0d stores checked, %0d errors", stores_seen, errors);
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: core.sv
// Top of the in-order RV32 subset pipeline: fetch, decode, scoreboard
// issue, register read, execute and write-back, with word stores out.
module core #(
  parameter int          LINE_WORDS = 4,
  parameter logic [31:0] RESET_PC   = 32'h0
) (
  input  logic                       clock,
  input  logic                       reset,
  output logic [31:0]                icache_addr,
  input  logic [LINE_WORDS*32-1:0]   icache_data,
  input  logic                       icache_valid,
  output pipe_pkg::store_req_t       dcache_store
);

  pipe_pkg::fetch_slot_t slot;
  pipe_pkg::uop_t        uop;
  pipe_pkg::wb_t         wb;
  logic                  issue;
  logic                  stall;
  logic [31:0]           rs1_data;
  logic [31:0]           rs2_data;

  fetch_unit #(
    .LINE_WORDS (LINE_WORDS),
    .RESET_PC   (RESET_PC)
  ) fetch (
    .clock        (clock),
    .reset        (reset),
    .stall        (stall),
    .icache_data  (icache_data),
    .icache_valid (icache_valid),
    .icache_addr  (icache_addr),
    .slot         (slot)
  );

  inst_decode decode (
    .clock (clock),
    .reset (reset),
    .stall (stall),
    .slot  (slot),
    .uop   (uop)
  );

  pipeline_control control (
    .clock (clock),
    .reset (reset),
    .uop   (uop),
    .wb    (wb),
    .issue (issue),
    .stall (stall)
  );

  // read indices come straight from the decode register
  reg_file regs (
    .clock    (clock),
    .reset    (reset),
    .rs1      (uop.rs1),
    .rs2      (uop.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  execute_unit execute (
    .clock        (clock),
    .reset        (reset),
    .issue        (issue),
    .uop          (uop),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .wb           (wb),
    .dcache_store (dcache_store)
  );

endmodule

// File: execute_unit.sv
// Single-cycle ALU stage. Registers the write-back record and, for SW,
// a one-cycle store pulse to the data cache.
module execute_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   issue,
  input  pipe_pkg::uop_t         uop,
  input  logic [31:0]            rs1_data,
  input  logic [31:0]            rs2_data,
  output pipe_pkg::wb_t          wb,
  output pipe_pkg::store_req_t   dcache_store
);

  logic [31:0] operand_b;
  logic [31:0] alu_result;

  always_comb begin
    // stores add the immediate to rs1 and send rs2 as data
    operand_b = (uop.uses_rs2 && !uop.is_store) ? rs2_data : uop.imm;
    case (uop.alu_op)
      isa_pkg::alu_add: alu_result = rs1_data + operand_b;
      isa_pkg::alu_sub: alu_result = rs1_data - operand_b;
      isa_pkg::alu_and: alu_result = rs1_data & operand_b;
      isa_pkg::alu_or:  alu_result = rs1_data | operand_b;
      isa_pkg::alu_xor: alu_result = rs1_data ^ operand_b;
      default:          alu_result = operand_b;
    endcase
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      wb.rd             <= uop.rd;
      wb.data           <= alu_result;
      dcache_store.addr <= alu_result;
      dcache_store.data <= rs2_data;
    end
    if (reset) begin
      wb.valid        <= 1'b0;
      dcache_store.we <= 1'b0;
    end else begin
      wb.valid        <= issue && uop.rd_write;
      dcache_store.we <= issue && uop.is_store;
    end
  end

endmodule

// File: reg_file.sv
// Integer register file, two combinational reads and one write port.
// x0 is hardwired to zero.
module reg_file (
  input  logic               clock,
  input  logic               reset,
  input  pipe_pkg::reg_idx_t rs1,
  input  pipe_pkg::reg_idx_t rs2,
  output logic [31:0]        rs1_data,
  output logic [31:0]        rs2_data,
  input  pipe_pkg::wb_t      wb
);

  logic [31:0] regs [1:31];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: pipeline_control.sv
// Scoreboard and issue decision. A micro-op waits in decode while any
// register it reads still has a write in flight.
module pipeline_control (
  input  logic           clock,
  input  logic           reset,
  input  pipe_pkg::uop_t uop,
  input  pipe_pkg::wb_t  wb,
  output logic           issue,
  output logic           stall
);

  logic [31:0] busy;
  logic [31:0] busy_next;
  logic        hazard;

  // x0 is never marked, so it never blocks
  assign hazard = (uop.uses_rs1 && busy[uop.rs1]) ||
                  (uop.uses_rs2 && busy[uop.rs2]);

  assign issue = uop.valid && !hazard;
  assign stall = uop.valid && hazard;

  always_comb begin
    busy_next = busy;
    if (wb.valid) begin
      busy_next[wb.rd] = 1'b0;
    end
    // a new writer of the same register wins over the retiring one
    if (issue && uop.rd_write) begin
      busy_next[uop.rd] = 1'b1;
    end
    busy_next[0] = 1'b0;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      busy <= busy_next;
    end
  end

endmodule

// File: inst_decode.sv
// Decode stage. Builds a micro-op from the fetched word and registers it.
// The register holds its micro-op while issue is stalled.
module inst_decode (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  stall,
  input  pipe_pkg::fetch_slot_t slot,
  output pipe_pkg::uop_t        uop
);

  isa_pkg::inst_u inst;
  pipe_pkg::uop_t uop_next;

  always_comb begin
    inst              = slot.inst;
    uop_next          = '0;
    uop_next.valid    = slot.valid;
    uop_next.rs1      = inst.r.rs1;
    uop_next.rs2      = inst.r.rs2;
    uop_next.rd       = inst.r.rd;
    uop_next.alu_op   = isa_pkg::alu_pass_b;
    // anything not matched below stays a no-op
    case (inst.r.opcode)
      isa_pkg::OP: begin
        if (inst.r.funct7 == isa_pkg::F7_BASE) begin
          case (inst.r.funct3)
            isa_pkg::F3_ADD_SUB: uop_next.alu_op = isa_pkg::alu_add;
            isa_pkg::F3_XOR:     uop_next.alu_op = isa_pkg::alu_xor;
            isa_pkg::F3_OR:      uop_next.alu_op = isa_pkg::alu_or;
            isa_pkg::F3_AND:     uop_next.alu_op = isa_pkg::alu_and;
            default:             uop_next.alu_op = isa_pkg::alu_pass_b;
          endcase
        end else if (inst.r.funct7 == isa_pkg::F7_SUB &&
                     inst.r.funct3 == isa_pkg::F3_ADD_SUB) begin
          uop_next.alu_op = isa_pkg::alu_sub;
        end
        if (uop_next.alu_op != isa_pkg::alu_pass_b) begin
          uop_next.uses_rs1 = 1'b1;
          uop_next.uses_rs2 = 1'b1;
          uop_next.rd_write = 1'b1;
        end
      end
      isa_pkg::OP_IMM: begin
        if (inst.i.funct3 == isa_pkg::F3_ADD_SUB) begin
          uop_next.alu_op   = isa_pkg::alu_add;
          uop_next.uses_rs1 = 1'b1;
          uop_next.rd_write = 1'b1;
          uop_next.imm      = {{(isa_pkg::xlen-12){inst.i.imm[11]}}, inst.i.imm};
        end
      end
      isa_pkg::STORE: begin
        if (inst.s.funct3 == isa_pkg::F3_SW) begin
          uop_next.alu_op   = isa_pkg::alu_add;
          uop_next.uses_rs1 = 1'b1;
          uop_next.uses_rs2 = 1'b1;
          uop_next.is_store = 1'b1;
          uop_next.imm      = {{(isa_pkg::xlen-12){inst.s.imm_hi[6]}},
                               inst.s.imm_hi, inst.s.imm_lo};
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      uop <= uop_next;
    end
    if (reset) begin
      uop.valid <= 1'b0;
    end
  end

endmodule

// File: fetch_unit.sv
// Instruction fetch. Waits for an icache line at icache_addr, then hands
// out one instruction per cycle while decode is not stalled.
module fetch_unit #(
  parameter int          LINE_WORDS = 4,
  parameter logic [31:0] RESET_PC   = 32'h0
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        stall,
  input  logic [LINE_WORDS*32-1:0]    icache_data,
  input  logic                        icache_valid,
  output logic [31:0]                 icache_addr,
  output pipe_pkg::fetch_slot_t       slot
);

  localparam int IDX_W = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(LINE_WORDS - 1);

  logic [LINE_WORDS*32-1:0] line;
  logic [IDX_W-1:0]         slot_idx;
  logic                     line_valid;

  // line only loads while empty
  always_ff @(posedge clock) begin
    if (!line_valid && icache_valid) begin
      line <= icache_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      icache_addr <= RESET_PC;
      slot_idx    <= '0;
      line_valid  <= 1'b0;
    end else if (!line_valid) begin
      if (icache_valid) begin
        line_valid <= 1'b1;
        slot_idx   <= '0;
      end
    end else if (!stall) begin
      if (slot_idx == LAST_IDX) begin
        // next line is requested once the last word is taken
        line_valid  <= 1'b0;
        icache_addr <= icache_addr + 32'(LINE_WORDS * 4);
      end else begin
        slot_idx <= slot_idx + 1'b1;
      end
    end
  end

  always_comb begin
    slot.valid = line_valid;
    slot.inst  = line[slot_idx*32 +: 32];
    slot.pc    = icache_addr + 32'({slot_idx, 2'b00});
  end

endmodule

// File: pipe_pkg.sv
// Records handed between pipeline stages and out to the data cache.
// Compile after isa_pkg, whose ALU op type rides inside the micro-op.
package pipe_pkg;

  typedef logic [4:0] reg_idx_t;

  typedef struct packed {
    logic                     valid;
    logic [31:0]              pc;
    logic [31:0]              inst;
  } fetch_slot_t;

  // one decoded instruction of about 55 bits
  typedef struct packed {
    logic                     valid;
    isa_pkg::alu_op_t         alu_op;
    reg_idx_t                 rs1;
    reg_idx_t                 rs2;
    logic                     uses_rs1;
    logic                     uses_rs2;
    reg_idx_t                 rd;
    logic                     rd_write;
    logic                     is_store;
    logic [isa_pkg::xlen-1:0] imm;
  } uop_t;

  typedef struct packed {
    logic                     valid;
    reg_idx_t                 rd;
    logic [31:0]              data;
  } wb_t;

  // word stores only
  typedef struct packed {
    logic                     we;
    logic [31:0]              addr;
    logic [31:0]              data;
  } store_req_t;

endpackage

// File: isa_pkg.sv
// RV32I subset encodings used by the small in-order core.
// Decode views each fetched word through inst_u to pull out its fields.
package isa_pkg;

  localparam int xlen = 32;

  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    STORE  = 7'b0100011
  } opcode_t;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SW      = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } r_format_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } i_format_t;

  // store immediate is split around rs2/rs1
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_t    opcode;
  } s_format_t;

  typedef union packed {
    r_format_t r;
    i_format_t i;
    s_format_t s;
  } inst_u;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_pass_b
  } alu_op_t;

endpackage
